// File: store_queue.f
hdl/sq_config_pkg.sv
hdl/sq_msg_pkg.sv
hdl/sq_pointers.sv
hdl/sq_entry_ram.sv
hdl/sq_forward.sv
hdl/sq_drain_fsm.sv
hdl/store_queue.sv
tests/sq_properties.sv
tests/sq_checker.sv
tests/tb_store_queue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f store_queue.f \
    --top-module tb_store_queue -o sim_store_queue \
    && ./obj_dir/sim_store_queue > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
exit 0

// File: tests/tb_store_queue.sv
`timescale 1ns/1ps

module tb_store_queue;

    localparam int NUM_ROWS = 36;

    // One stimulus row
    // An rdy of 2 draws mem_ready from the LFSR
    typedef struct packed {
        logic [1:0]  cnt;
        logic [31:0] a0;
        logic [31:0] d0;
        logic [31:0] a1;
        logic [31:0] d1;
        logic [1:0]  commit;
        logic        flush;
        logic [31:0] laddr;
        logic [1:0]  rdy;
        logic        chk;
        logic        hit;
        logic [31:0] data;
    } row_t;

    logic                       clock = 1'b0;
    logic                       reset = 1'b1;
    sq_msg_pkg::sq_dispatch_t   dispatch = '0;
    sq_config_pkg::lane_count_t spots;
    sq_config_pkg::lane_count_t commit_count = '0;
    logic                       flush = 1'b0;
    sq_msg_pkg::sq_load_req_t   load_req = '0;
    sq_msg_pkg::sq_load_resp_t  load_resp;
    sq_msg_pkg::sq_mem_write_t  mem_write;
    logic                       mem_valid;
    logic                       mem_ready = 1'b0;

    // Row info handed to the checker
    logic                 row_active = 1'b0;
    int                   row_idx = 0;
    logic                 chk = 1'b0;
    logic                 exp_hit = 1'b0;
    sq_config_pkg::data_t exp_data = '0;
    logic                 drained;
    int                   error_count;
    int                   check_count;

    row_t table_rows [NUM_ROWS];
    logic [7:0] lfsr = 8'd53;

    always #20 clock = ~clock;

    store_queue u_store_queue (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .spots        (spots),
        .commit_count (commit_count),
        .flush        (flush),
        .load_req     (load_req),
        .load_resp    (load_resp),
        .mem_write    (mem_write),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready)
    );

    sq_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (u_store_queue.dispatch),
        .spots        (u_store_queue.spots),
        .commit_count (u_store_queue.commit_count),
        .flush        (u_store_queue.flush),
        .load_req     (u_store_queue.load_req),
        .load_resp    (u_store_queue.load_resp),
        .mem_write    (u_store_queue.mem_write),
        .mem_valid    (u_store_queue.mem_valid),
        .mem_ready    (u_store_queue.mem_ready),
        .row_active   (row_active),
        .row_idx      (row_idx),
        .chk          (chk),
        .exp_hit      (exp_hit),
        .exp_data     (exp_data),
        .drained      (drained),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // Fibonacci taps 8,6,5,4
    function automatic logic [7:0] next_lfsr(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic fill_table();
        // Empty queue and then visibility one cycle after dispatch
        table_rows[0]  = '{0, 0, 0, 0, 0, 0, 0, 32'h100, 1, 1, 0, 0};
        table_rows[1]  = '{2, 32'h100, 32'h11, 32'h104, 32'h22, 0, 0, 32'h100, 1, 1, 0, 0};
        table_rows[2]  = '{2, 32'h100, 32'h33, 32'h108, 32'h44, 0, 0, 32'h102, 1, 1, 1, 32'h11};
        table_rows[3]  = '{0, 0, 0, 0, 0, 0, 0, 32'h101, 0, 1, 1, 32'h33};
        table_rows[4]  = '{2, 32'h10c, 32'h55, 32'h110, 32'h66, 0, 0, 32'h10c, 0, 1, 0, 0};
        table_rows[5]  = '{2, 32'h114, 32'h77, 32'h118, 32'h88, 0, 0, 32'h10c, 0, 1, 1, 32'h55};
        // Full queue and commit under back-pressure
        table_rows[6]  = '{0, 0, 0, 0, 0, 2, 0, 32'h118, 0, 1, 1, 32'h88};
        table_rows[7]  = '{0, 0, 0, 0, 0, 2, 0, 32'h100, 0, 1, 1, 32'h33};
        for (int i = 8; i < 12; i++) begin
            table_rows[i] = '{0, 0, 0, 0, 0, 0, 0, 32'h104, 2, 0, 0, 0};
        end
        // Flush drops speculative stores and same-cycle dispatch
        table_rows[12] = '{2, 32'h200, 32'h99, 32'h204, 32'h9a, 0, 1, 32'h10c, 1, 1, 1, 32'h55};
        table_rows[13] = '{0, 0, 0, 0, 0, 0, 0, 32'h10c, 1, 1, 0, 0};
        table_rows[14] = '{0, 0, 0, 0, 0, 0, 0, 32'h200, 1, 1, 0, 0};
        table_rows[15] = '{2, 32'h120, 32'ha1, 32'h124, 32'ha2, 0, 0, 32'h108, 1, 0, 0, 0};
        // Wraparound with a repeated word address
        for (int k = 0; k < 12; k++) begin
            table_rows[16 + k] = '{2, 32'h140 + 8 * k, 32'hc0 + k,
                                   (k % 3 == 0) ? 32'h300 : 32'h144 + 8 * k, 32'hd0 + k,
                                   2, 0, 32'h302, (k % 2 == 0) ? 2'd2 : 2'd1, 0, 0, 0};
        end
        for (int i = 28; i < NUM_ROWS; i++) begin
            table_rows[i] = '{0, 0, 0, 0, 0, 2, 0, 32'h300, 1, 0, 0, 0};
        end
    endtask

    initial begin
        int pending;
        int deff;
        int ceff;
        int waited;
        logic timed_out;
        row_t r;

        pending = 0;
        timed_out = 1'b0;
        fill_table();
        repeat (16) @(posedge clock);
        #2 reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clock);
            #2;
            r = table_rows[i];
            // Dispatch stays within spots and commit within pending stores
            deff = (int'(r.cnt) < int'(spots)) ? int'(r.cnt) : int'(spots);
            ceff = (int'(r.commit) < pending) ? int'(r.commit) : pending;
            dispatch.lanes[0] = '{addr: r.a0, data: r.d0};
            dispatch.lanes[1] = '{addr: r.a1, data: r.d1};
            dispatch.count = deff[1:0];
            commit_count = ceff[1:0];
            flush = r.flush;
            load_req.addr = r.laddr;
            if (r.rdy == 2'd2) begin
                lfsr = next_lfsr(lfsr);
                mem_ready = lfsr[0];
            end else begin
                mem_ready = r.rdy[0];
            end
            pending = r.flush ? 0 : pending - ceff + deff;
            row_active = 1'b1;
            row_idx = i;
            chk = r.chk;
            exp_hit = r.hit;
            exp_data = r.data;
        end

        @(posedge clock);
        #2;
        row_active = 1'b0;
        dispatch.count = '0;
        commit_count = '0;
        flush = 1'b0;
        mem_ready = 1'b1;

        // Let committed stores finish draining
        // Sampled after the edge once the FSM state has settled
        waited = 0;
        while (!(drained && !mem_valid) && !timed_out) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > 400) timed_out = 1'b1;
        end
        if (timed_out) $display("timeout while waiting for the queue to drain");

        $display("rows %0d checks %0d errors %0d", NUM_ROWS, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/sq_checker.sv
`timescale 1ns/1ps

module sq_checker (
    input  logic                       clock,
    input  logic                       reset,
    input  sq_msg_pkg::sq_dispatch_t   dispatch,
    input  sq_config_pkg::lane_count_t spots,
    input  sq_config_pkg::lane_count_t commit_count,
    input  logic                       flush,
    input  sq_msg_pkg::sq_load_req_t   load_req,
    input  sq_msg_pkg::sq_load_resp_t  load_resp,
    input  sq_msg_pkg::sq_mem_write_t  mem_write,
    input  logic                       mem_valid,
    input  logic                       mem_ready,
    input  logic                       row_active,
    input  int                         row_idx,
    input  logic                       chk,
    input  logic                       exp_hit,
    input  sq_config_pkg::data_t       exp_data,
    output logic                       drained,
    output int                         error_count,
    output int                         check_count
);

    // Queue model with the oldest store first
    // The first n_comm entries are committed
    sq_config_pkg::addr_t model_addr[$];
    sq_config_pkg::data_t model_data[$];
    int n_comm = 0;
    int row_errors = 0;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // No committed store is left waiting for the cache
    assign drained = (n_comm == 0);

    // Wrong value with expected and actual in hex
    task automatic flag_mismatch(
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] got
    );
        $display("ERR %s exp 0x%08h got 0x%08h", name, exp, got);
        error_count++;
        row_errors++;
    endtask

    // Failure with no single value to show
    task automatic note_failure(input string what);
        $display("row %0d: %s", row_idx, what);
        error_count++;
        row_errors++;
    endtask

    // Outputs and inputs are both stable at the falling edge
    // Model then steps to the state after the coming rising edge
    always @(negedge clock) begin
        int free;
        logic [1:0] exp_spots;
        logic hit;
        sq_config_pkg::data_t fwd;

        if (reset) begin
            model_addr.delete();
            model_data.delete();
            n_comm = 0;
        end else begin
            free = sq_config_pkg::SQ_DEPTH - model_addr.size();
            exp_spots = (free < 2) ? free[1:0] : 2'd2;
            check_count++;
            if (spots !== exp_spots) begin
                flag_mismatch("spots", 32'(exp_spots), 32'(spots));
            end

            // Youngest matching word wins
            hit = 1'b0;
            fwd = '0;
            foreach (model_addr[i]) begin
                if (model_addr[i][31:2] == load_req.addr[31:2]) begin
                    hit = 1'b1;
                    fwd = model_data[i];
                end
            end
            check_count++;
            if (load_resp.hit !== hit) begin
                flag_mismatch("load_resp.hit", 32'(hit), 32'(load_resp.hit));
            end else if (hit && load_resp.data !== fwd) begin
                flag_mismatch("load_resp.data", fwd, load_resp.data);
            end

            // Hand-derived row expectations
            if (row_active && chk) begin
                check_count++;
                if (load_resp.hit !== exp_hit) begin
                    flag_mismatch("load_resp.hit", 32'(exp_hit), 32'(load_resp.hit));
                end else if (exp_hit && load_resp.data !== exp_data) begin
                    flag_mismatch("load_resp.data", exp_data, load_resp.data);
                end
            end

            // Only the oldest committed store may be offered
            if (mem_valid && n_comm == 0) note_failure("cache request without a committed store");
            if (mem_valid && mem_ready && n_comm > 0) begin
                check_count++;
                if (mem_write.addr !== model_addr[0]) begin
                    flag_mismatch("mem_write.addr", model_addr[0], mem_write.addr);
                end
                if (mem_write.data !== model_data[0]) begin
                    flag_mismatch("mem_write.data", model_data[0], mem_write.data);
                end
                void'(model_addr.pop_front());
                void'(model_data.pop_front());
                n_comm--;
            end

            n_comm += int'(commit_count);
            if (n_comm > model_addr.size()) note_failure("commit beyond the stored entries");

            if (flush) begin
                // Speculative stores vanish and dispatch is dropped
                while (model_addr.size() > n_comm) begin
                    void'(model_addr.pop_back());
                    void'(model_data.pop_back());
                end
            end else begin
                for (int i = 0; i < int'(dispatch.count); i++) begin
                    model_addr.push_back(dispatch.lanes[i].addr);
                    model_data.push_back(dispatch.lanes[i].data);
                end
            end

            if (row_active) begin
                $display("row %0d done, %0d errors", row_idx, row_errors);
                row_errors = 0;
            end
        end
    end

endmodule

// File: tests/sq_properties.sv
`timescale 1ns/1ps

module sq_properties (
    input logic                      clock,
    input logic                      reset,
    input logic                      mem_valid,
    input logic                      mem_ready,
    input sq_msg_pkg::sq_mem_write_t mem_write,
    input sq_config_pkg::sq_count_t  committed_count,
    input sq_config_pkg::sq_count_t  total_count
);

    // A stalled cache request keeps valid and payload until accepted
    hold_under_stall: assert property (@(posedge clock) disable iff (reset)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_write)))
        else $error("cache request changed while stalled");

    // No request straight out of reset
    idle_after_reset: assert property (@(posedge clock)
        reset |=> !mem_valid)
        else $error("mem_valid high after reset");

    // Committed entries are a subset of all entries
    committed_within_total: assert property (@(posedge clock) disable iff (reset)
        committed_count <= total_count)
        else $error("committed count above total count");

endmodule

bind store_queue sq_properties u_properties (
    .clock           (clock),
    .reset           (reset),
    .mem_valid       (mem_valid),
    .mem_ready       (mem_ready),
    .mem_write       (mem_write),
    .committed_count (committed_count),
    .total_count     (total_count)
);

// File: hdl/store_queue.sv
`timescale 1ns/1ps

module store_queue (
    input  logic                       clock,
    input  logic                       reset,
    input  sq_msg_pkg::sq_dispatch_t   dispatch,
    output sq_config_pkg::lane_count_t spots,
    input  sq_config_pkg::lane_count_t commit_count,
    input  logic                       flush,
    input  sq_msg_pkg::sq_load_req_t   load_req,
    output sq_msg_pkg::sq_load_resp_t  load_resp,
    output sq_msg_pkg::sq_mem_write_t  mem_write,
    output logic                       mem_valid,
    input  logic                       mem_ready
);

    // Pointer state
    sq_config_pkg::sq_idx_t     head;
    sq_config_pkg::sq_idx_t     tail;
    sq_config_pkg::sq_count_t   total_count;
    sq_config_pkg::sq_count_t   committed_count;
    sq_config_pkg::lane_count_t write_count;

    // Drain handshake back to the pointers
    logic pop;

    // Storage views
    sq_msg_pkg::sq_store_t                              head_entry;
    sq_msg_pkg::sq_store_t                              next_entry;
    sq_msg_pkg::sq_store_t [sq_config_pkg::SQ_DEPTH-1:0] entries;

    sq_pointers u_pointers (
        .clock           (clock),
        .reset           (reset),
        .dispatch_count  (dispatch.count),
        .commit_count    (commit_count),
        .flush           (flush),
        .pop             (pop),
        .head            (head),
        .tail            (tail),
        .total_count     (total_count),
        .committed_count (committed_count),
        .spots           (spots),
        .write_count     (write_count)
    );

    // write_count is already zero during a flush
    sq_entry_ram u_entry_ram (
        .clock       (clock),
        .reset       (reset),
        .tail        (tail),
        .write_count (write_count),
        .stores      (dispatch.lanes),
        .head        (head),
        .head_entry  (head_entry),
        .next_entry  (next_entry),
        .entries     (entries)
    );

    sq_forward u_forward (
        .load_req    (load_req),
        .entries     (entries),
        .head        (head),
        .total_count (total_count),
        .load_resp   (load_resp)
    );

    sq_drain_fsm u_drain_fsm (
        .clock           (clock),
        .reset           (reset),
        .committed_count (committed_count),
        .head_entry      (head_entry),
        .next_entry      (next_entry),
        .mem_ready       (mem_ready),
        .mem_write       (mem_write),
        .mem_valid       (mem_valid),
        .pop             (pop)
    );

endmodule

// File: hdl/sq_drain_fsm.sv
`timescale 1ns/1ps

module sq_drain_fsm (
    input  logic                      clock,
    input  logic                      reset,
    input  sq_config_pkg::sq_count_t  committed_count,
    input  sq_msg_pkg::sq_store_t     head_entry,
    input  sq_msg_pkg::sq_store_t     next_entry,
    input  logic                      mem_ready,
    output sq_msg_pkg::sq_mem_write_t mem_write,
    output logic                      mem_valid,
    output logic                      pop
);

    sq_msg_pkg::drain_state_t state;
    sq_msg_pkg::drain_state_t next_state;

    // Payload load control
    logic                  load_en;
    sq_msg_pkg::sq_store_t load_src;

    // Request stays up for the whole SEND state, so it cannot drop under stall
    assign mem_valid = (state == sq_msg_pkg::DRAIN_SEND);

    // Accepted transfer retires the head entry
    assign pop = mem_valid && mem_ready;

    always_comb begin
        next_state = state;
        load_en    = 1'b0;
        load_src   = head_entry;

        case (state)
            sq_msg_pkg::DRAIN_IDLE: begin
                // Nothing in flight, the head is the oldest committed store
                if (committed_count != '0) begin
                    load_en    = 1'b1;
                    next_state = sq_msg_pkg::DRAIN_SEND;
                end
            end
            sq_msg_pkg::DRAIN_SEND: begin
                if (mem_ready) begin
                    // Count still includes the entry being accepted now
                    if (committed_count > sq_config_pkg::sq_count_t'(1)) begin
                        load_en  = 1'b1;
                        load_src = next_entry;
                    end else begin
                        next_state = sq_msg_pkg::DRAIN_IDLE;
                    end
                end
            end
            default: begin
                next_state = sq_msg_pkg::DRAIN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= sq_msg_pkg::DRAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Request payload, held until the next load
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem_write.addr <= load_src.addr;
            mem_write.data <= load_src.data;
        end
    end

endmodule

// File: hdl/sq_forward.sv
`timescale 1ns/1ps

module sq_forward (
    input  sq_msg_pkg::sq_load_req_t                            load_req,
    input  sq_msg_pkg::sq_store_t [sq_config_pkg::SQ_DEPTH-1:0] entries,
    input  sq_config_pkg::sq_idx_t                              head,
    input  sq_config_pkg::sq_count_t                            total_count,
    output sq_msg_pkg::sq_load_resp_t                           load_resp
);

    // Word address of the load, byte offset bits dropped
    logic [sq_config_pkg::ADDR_BITS-3:0] load_word;

    assign load_word = load_req.addr[sq_config_pkg::ADDR_BITS-1:2];

    // Walk from oldest to youngest
    // Each later match overwrites the earlier one so the youngest store wins
    always_comb begin
        sq_config_pkg::sq_idx_t idx;
        sq_msg_pkg::sq_store_t  ent;

        load_resp = '0;
        idx       = head;
        ent       = '0;

        for (int i = 0; i < sq_config_pkg::SQ_DEPTH; i++) begin
            idx = head + sq_config_pkg::sq_idx_t'(i);
            ent = entries[idx];

            // Slots past the occupancy are stale
            // Committed but undrained entries still count
            if (i < int'(total_count)) begin
                if (ent.addr[sq_config_pkg::ADDR_BITS-1:2] == load_word) begin
                    load_resp.hit  = 1'b1;
                    load_resp.data = ent.data;
                end
            end
        end
    end

endmodule

// File: hdl/sq_entry_ram.sv
`timescale 1ns/1ps

module sq_entry_ram (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  sq_config_pkg::sq_idx_t                                 tail,
    input  sq_config_pkg::lane_count_t                             write_count,
    input  sq_msg_pkg::sq_store_t [sq_config_pkg::DISPATCH_WIDTH-1:0] stores,
    input  sq_config_pkg::sq_idx_t                                 head,
    output sq_msg_pkg::sq_store_t                                  head_entry,
    output sq_msg_pkg::sq_store_t                                  next_entry,
    output sq_msg_pkg::sq_store_t [sq_config_pkg::SQ_DEPTH-1:0]       entries
);

    // Storage array, flat so the search sees every slot
    sq_msg_pkg::sq_store_t [sq_config_pkg::SQ_DEPTH-1:0] mem;

    // Slot index of each dispatch lane
    sq_config_pkg::sq_idx_t [sq_config_pkg::DISPATCH_WIDTH-1:0] lane_idx;

    // Lanes land at consecutive slots from the tail and wrap past the top
    always_comb begin
        for (int i = 0; i < sq_config_pkg::DISPATCH_WIDTH; i++) begin
            lane_idx[i] = tail + sq_config_pkg::sq_idx_t'(i);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem <= '0;
        end else begin
            // Only lanes below the count are live
            for (int i = 0; i < sq_config_pkg::DISPATCH_WIDTH; i++) begin
                if (i < int'(write_count)) begin
                    mem[lane_idx[i]] <= stores[i];
                end
            end
        end
    end

    // Oldest entry for the drain FSM
    assign head_entry = mem[head];

    // Entry behind the head, used for back-to-back draining
    // before the head pointer has moved
    assign next_entry = mem[head + sq_config_pkg::sq_idx_t'(1)];

    // Whole array for forwarding
    assign entries = mem;

endmodule

// File: hdl/sq_pointers.sv
`timescale 1ns/1ps

module sq_pointers (
    input  logic                       clock,
    input  logic                       reset,
    input  sq_config_pkg::lane_count_t dispatch_count,
    input  sq_config_pkg::lane_count_t commit_count,
    input  logic                       flush,
    input  logic                       pop,
    output sq_config_pkg::sq_idx_t     head,
    output sq_config_pkg::sq_idx_t     tail,
    output sq_config_pkg::sq_count_t   total_count,
    output sq_config_pkg::sq_count_t   committed_count,
    output sq_config_pkg::lane_count_t spots,
    output sq_config_pkg::lane_count_t write_count
);

    // Boundary between committed and speculative entries
    sq_config_pkg::sq_idx_t   commit_ptr;

    sq_config_pkg::sq_idx_t   next_head;
    sq_config_pkg::sq_idx_t   next_commit_ptr;
    sq_config_pkg::sq_idx_t   next_tail;
    sq_config_pkg::sq_count_t next_total_count;
    sq_config_pkg::sq_count_t next_committed_count;
    sq_config_pkg::sq_count_t free_count;

    // Flush drops this cycle's dispatch, storage only looks at write_count
    assign write_count = flush ? '0 : dispatch_count;

    // Free entries as seen before this edge
    assign free_count = sq_config_pkg::sq_count_t'(sq_config_pkg::SQ_DEPTH) - total_count;

    // Offer at most one dispatch group worth of spots
    always_comb begin
        if (free_count < sq_config_pkg::sq_count_t'(sq_config_pkg::DISPATCH_WIDTH)) begin
            spots = sq_config_pkg::lane_count_t'(free_count);
        end else begin
            spots = sq_config_pkg::lane_count_t'(sq_config_pkg::DISPATCH_WIDTH);
        end
    end

    always_comb begin
        // Index arithmetic wraps at the depth
        next_head       = head + sq_config_pkg::sq_idx_t'(pop);
        next_commit_ptr = commit_ptr + sq_config_pkg::sq_idx_t'(commit_count);

        // A pop always takes a committed entry
        next_committed_count = committed_count
                             + sq_config_pkg::sq_count_t'(commit_count)
                             - sq_config_pkg::sq_count_t'(pop);

        if (flush) begin
            // Speculative entries vanish, the tail snaps back
            next_tail        = next_commit_ptr;
            next_total_count = next_committed_count;
        end else begin
            next_tail        = tail + sq_config_pkg::sq_idx_t'(write_count);
            next_total_count = total_count
                             + sq_config_pkg::sq_count_t'(write_count)
                             - sq_config_pkg::sq_count_t'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head            <= '0;
            commit_ptr      <= '0;
            tail            <= '0;
            total_count     <= '0;
            committed_count <= '0;
        end else begin
            head            <= next_head;
            commit_ptr      <= next_commit_ptr;
            tail            <= next_tail;
            total_count     <= next_total_count;
            committed_count <= next_committed_count;
        end
    end

endmodule

// File: hdl/sq_msg_pkg.sv
// Messages exchanged between the queue blocks and its neighbours
package sq_msg_pkg;

    // A resolved store as it sits in the queue
    typedef struct packed {
        sq_config_pkg::addr_t addr;
        sq_config_pkg::data_t data;
    } sq_store_t;

    // Dispatch bundle
    // Lanes below count carry live stores, lane 0 is the oldest
    typedef struct packed {
        sq_store_t [sq_config_pkg::DISPATCH_WIDTH-1:0] lanes;
        sq_config_pkg::lane_count_t                    count;
    } sq_dispatch_t;

    // Load search request
    typedef struct packed {
        sq_config_pkg::addr_t addr;
    } sq_load_req_t;

    // Forwarding answer, data only meaningful on a hit
    typedef struct packed {
        logic                 hit;
        sq_config_pkg::data_t data;
    } sq_load_resp_t;

    // Write request toward the data cache
    typedef struct packed {
        sq_config_pkg::addr_t addr;
        sq_config_pkg::data_t data;
    } sq_mem_write_t;

    // Drain FSM states
    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_SEND
    } drain_state_t;

endpackage

// File: hdl/sq_config_pkg.sv
// Sizes and widths of the store queue
package sq_config_pkg;

    // Queue geometry
    localparam int SQ_DEPTH = 8;
    // Depth is a power of two so indices wrap on their own
    localparam int SQ_IDX_BITS = $clog2(SQ_DEPTH);
    // Occupancy has to reach SQ_DEPTH itself
    localparam int SQ_COUNT_BITS = $clog2(SQ_DEPTH + 1);

    // Superscalar width of dispatch and commit
    localparam int DISPATCH_WIDTH = 2;
    // Holds 0 up to DISPATCH_WIDTH
    localparam int WIDTH_BITS = $clog2(DISPATCH_WIDTH + 1);

    // Memory word geometry
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;

    // Byte address
    typedef logic [ADDR_BITS-1:0] addr_t;

    // One store data word
    typedef logic [DATA_BITS-1:0] data_t;

    // Entry index into the circular buffer
    typedef logic [SQ_IDX_BITS-1:0] sq_idx_t;

    // Number of entries, 0 to SQ_DEPTH
    typedef logic [SQ_COUNT_BITS-1:0] sq_count_t;

    // Per-cycle count of dispatch, commit or free spots
    typedef logic [WIDTH_BITS-1:0] lane_count_t;

endpackage
